// File: cm0_alu_pipe.f
+incdir+dv
hdl/alu_pkg.sv
hdl/bus_pkg.sv
hdl/alu_operand_stage.sv
hdl/alu_execute_stage.sv
hdl/agu_bus_stage.sv
hdl/cm0_alu_pipe.sv
dv/cm0_alu_pipe_properties.sv
dv/cm0_alu_pipe_tb.sv

// File: dv/cm0_alu_pipe_properties.sv
`default_nettype none

module cm0_alu_pipe_properties (
   input wire hclk_i,
   input wire rst_n_i,
   input wire in_valid_i,
   input wire out_valid_i,
   input wire ext_trans_i,
   input wire ppb_trans_i,
   input wire align_err_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // read back by the testbench at the end of the run
   int assert_fails = 0;

   // two register stages between the input and output strobes
   valid_latency: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      out_valid_i == $past(in_valid_i, 2))
   else begin
      $error("out_valid_o does not follow in_valid_i by two cycles");
      assert_fails++;
   end

   // a transaction goes to one bus only
   one_bus: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      !(ext_trans_i && ppb_trans_i))
   else begin
      $error("ext_trans_o and ppb_trans_o both high");
      assert_fails++;
   end

   // misaligned accesses are dropped
   align_blocks: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      !(align_err_i && (ext_trans_i || ppb_trans_i)))
   else begin
      $error("align_err_o high together with a transaction strobe");
      assert_fails++;
   end

endmodule

bind cm0_alu_pipe cm0_alu_pipe_properties props_i (
   .hclk_i      (hclk_i),
   .rst_n_i     (rst_n_i),
   .in_valid_i  (in_valid_i),
   .out_valid_i (out_valid_o),
   .ext_trans_i (ext_trans_o),
   .ppb_trans_i (ppb_trans_o),
   .align_err_i (align_err_o)
);

`default_nettype wire

// File: dv/cm0_alu_pipe_tests.svh
`ifndef CM0_ALU_PIPE_TESTS_SVH
`define CM0_ALU_PIPE_TESTS_SVH

// ------------------------------------------------------------
// stimulus helpers, all called on a falling edge
// ------------------------------------------------------------

task automatic drive_item(input alu_op_e op_v, input opb_src_e src_v, input logic [11:0] imm_v,
                          input logic [31:0] a, input logic [31:0] b, input logic cf,
                          input logic en_v, input logic sel_v, input hsize_e size_v,
                          input logic idle_v, input logic kill_v);
   in_valid   = 1'b1;
   op         = op_v;
   opb_src    = src_v;
   imm        = imm_v;
   ra         = a;
   rb         = b;
   cflag_in   = cf;
   agu_en     = en_v;
   agu_sel_ra = sel_v;
   ls_size    = size_v;
   bus_idle   = idle_v;
   kill_addr  = kill_v;
endtask

// one item alone, returns on the falling edge where its result is out
task automatic run_item(input alu_op_e op_v, input opb_src_e src_v, input logic [11:0] imm_v,
                        input logic [31:0] a, input logic [31:0] b, input logic cf,
                        input logic en_v, input logic sel_v, input hsize_e size_v,
                        input logic idle_v, input logic kill_v);
   drive_item(op_v, src_v, imm_v, a, b, cf, en_v, sel_v, size_v, idle_v, kill_v);
   @(negedge hclk);
   in_valid = 1'b0;
   @(negedge hclk);
   check_value("out_valid_o", 32'd1, 32'(out_valid));
endtask

// bus outputs expected for a raw address
task automatic check_bus(input logic [31:0] raw, input hsize_e size_v, input logic en_v,
                         input logic supp_v);
   logic [1:0] mask;
   logic       ua;
   logic       go;
   mask = 2'b00;
   if (en_v && size_v == SIZE_HALF) mask = 2'b01;
   if (en_v && size_v == SIZE_WORD) mask = 2'b11;
   ua = en_v && ((raw[1:0] & mask) != 2'b00);
   go = en_v && !ua && !supp_v;
   check_value("haddr_o", raw & ~{30'd0, mask}, haddr);
   check_value("hsize_o", 32'(en_v ? size_v : SIZE_BYTE), 32'(hsize));
   check_value("align_err_o", 32'(ua), 32'(align_err));
   check_value("ppb_trans_o", 32'(go && raw[31:28] == PPB_NIBBLE_DEF), 32'(ppb_trans));
   check_value("ext_trans_o", 32'(go && raw[31:28] != PPB_NIBBLE_DEF), 32'(ext_trans));
endtask

// ------------------------------------------------------------
// directed tests
// ------------------------------------------------------------

task automatic test_reset();
   check_value("out_valid_o", 32'd0, 32'(out_valid));
   check_value("ext_trans_o", 32'd0, 32'(ext_trans));
   check_value("ppb_trans_o", 32'd0, 32'(ppb_trans));
   check_value("align_err_o", 32'd0, 32'(align_err));
endtask

task automatic test_logic();
   alu_op_e     ops[6] = '{AND, BIC, EOR, ORR, MOV, MVN};
   logic [31:0] a;
   logic [31:0] b;
   logic [33:0] exp;
   foreach (ops[i]) begin
      repeat (4) begin
         a   = $random(seed);
         b   = $random(seed);
         exp = alu_model(ops[i], a, b, 1'b0);
         run_item(ops[i], REG, 12'h000, a, b, 1'b0, 1'b0, 1'b0, SIZE_BYTE, 1'b0, 1'b0);
         check_value("res_o", exp[31:0], res);
      end
   end
endtask

// four corner pairs then one random item per op, source and carry
task automatic test_arith();
   alu_op_e     ops[5]    = '{ADD, ADC, SUB, SBC, RSB};
   logic [31:0] a_c[4]    = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'h7fff_ffff};
   logic [31:0] b_c[4]    = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
   logic [11:0] imm_c[4]  = '{12'h000, 12'h7ff, 12'h800, 12'hfff};
   logic [31:0] a;
   logic [31:0] b;
   logic [11:0] im;
   opb_src_e    src;
   logic [33:0] exp;
   foreach (ops[i]) begin
      for (int s = 0; s < 6; s++) begin
         for (int c = 0; c < 2; c++) begin
            for (int k = 0; k < 5; k++) begin
               src = opb_src_e'(3'(s));
               if (k < 4) begin
                  a  = a_c[k];
                  b  = b_c[k];
                  im = imm_c[k];
               end else begin
                  a  = $random(seed);
                  b  = $random(seed);
                  im = 12'($random(seed));
               end
               exp = alu_model(ops[i], a, opb_model(src, im, b), c[0]);
               run_item(ops[i], src, im, a, b, c[0], 1'b0, 1'b0, SIZE_BYTE, 1'b0, 1'b0);
               check_value("res_o", exp[31:0], res);
               check_value("cflag_o", 32'(exp[32]), 32'(cflag_out));
               check_value("vflag_o", 32'(exp[33]), 32'(vflag_out));
            end
         end
      end
   end
endtask

task automatic test_address();
   hsize_e      sizes[3] = '{SIZE_BYTE, SIZE_HALF, SIZE_WORD};
   logic [31:0] raw;
   logic [31:0] a;
   logic [31:0] b;
   foreach (sizes[i]) begin
      for (int low = 0; low < 4; low++) begin
         for (int sel = 0; sel < 2; sel++) begin
            raw = {30'($random(seed)), 2'(low)};
            if (sel[0]) begin
               // odd b moves the sum off raw, so only a can give the address
               a = raw;
               b = $random(seed) | 32'h1;
            end else begin
               // from the sum, b is picked so that a + b lands on raw
               a = $random(seed);
               b = raw - a;
            end
            run_item(ADD, REG, 12'h000, a, b, 1'b0, 1'b1, sel[0], sizes[i],
                     1'b0, 1'b0);
            check_bus(raw, sizes[i], 1'b1, 1'b0);
         end
      end
   end
endtask

task automatic test_routing();
   logic [3:0]  nibs[4] = '{PPB_NIBBLE_DEF, 4'h0, 4'h2, 4'hf};
   logic [31:0] raw;
   foreach (nibs[i]) begin
      // plain, then bus idle, then kill
      for (int sup = 0; sup < 3; sup++) begin
         raw = {nibs[i], 26'($random(seed)), 2'b00};
         run_item(MOV, REG, 12'h000, raw, raw, 1'b0, 1'b1, 1'b1, SIZE_WORD,
                  sup == 1, sup == 2);
         check_bus(raw, SIZE_WORD, 1'b1, sup != 0);
      end
   end
   // no load or store in the item
   raw = {PPB_NIBBLE_DEF, 28'h000_0013};
   run_item(MOV, REG, 12'h000, raw, raw, 1'b0, 1'b0, 1'b1, SIZE_WORD, 1'b0, 1'b0);
   check_bus(raw, SIZE_WORD, 1'b0, 1'b0);
endtask

// eight items back to back, results must leave in order
task automatic test_burst();
   logic [33:0] exp_q[$];
   alu_op_e     op_q[$];
   logic [33:0] exp;
   alu_op_e     op_v;
   logic [31:0] a;
   logic [31:0] b;
   logic        cf;
   int          seen;
   seen = 0;
   // let the last single item drain first
   @(negedge hclk);
   for (int cyc = 0; cyc < 12; cyc++) begin
      check_value("out_valid_o", 32'(cyc >= 2 && cyc < 10), 32'(out_valid));
      if (out_valid) begin
         seen++;
         exp  = exp_q.pop_front();
         op_v = op_q.pop_front();
         check_value("res_o", exp[31:0], res);
         if (op_v inside {ADD, ADC, SUB, SBC, RSB}) begin
            check_value("cflag_o", 32'(exp[32]), 32'(cflag_out));
            check_value("vflag_o", 32'(exp[33]), 32'(vflag_out));
         end
      end
      if (cyc < 8) begin
         op_v = alu_op_e'(4'($unsigned($random(seed)) % 11));
         a    = $random(seed);
         b    = $random(seed);
         cf   = 1'($random(seed));
         exp_q.push_back(alu_model(op_v, a, b, cf));
         op_q.push_back(op_v);
         drive_item(op_v, REG, 12'h000, a, b, cf, 1'b0, 1'b0, SIZE_BYTE, 1'b0, 1'b0);
      end else begin
         in_valid = 1'b0;
      end
      @(negedge hclk);
   end
   check_value("out_valid_o cycles", 32'd8, 32'(seen));
endtask

`endif

// File: dv/cm0_alu_pipe_tb.sv
`default_nettype none

module cm0_alu_pipe_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import alu_pkg::*;
   import bus_pkg::*;

   // items per test, each single item takes two cycles
   localparam int N_LOGIC     = 24;
   localparam int N_ARITH     = 300;
   localparam int N_ADDR      = 24;
   localparam int N_ROUTE     = 13;
   localparam int TEST_CYCLES = 2 * (N_LOGIC + N_ARITH + N_ADDR + N_ROUTE) + 20;
   // extra cycles before the watchdog fires
   localparam int MARGIN      = 200;

   // ------------------------------------------------------------
   // DUT signals
   // ------------------------------------------------------------

   logic              hclk = 1'b0;
   logic              rst_n;
   logic              in_valid;
   alu_op_e           op;
   opb_src_e          opb_src;
   logic [11:0]       imm;
   logic [DATA_W-1:0] ra;
   logic [DATA_W-1:0] rb;
   logic              cflag_in;
   logic              agu_en;
   logic              agu_sel_ra;
   hsize_e            ls_size;
   logic              bus_idle;
   logic              kill_addr;

   logic              out_valid;
   logic [DATA_W-1:0] res;
   logic              cflag_out;
   logic              vflag_out;
   logic [ADDR_W-1:0] haddr;
   hsize_e            hsize;
   logic              ext_trans;
   logic              ppb_trans;
   logic              align_err;

   int                seed;
   int                errors;
   int                checks;

   // 10 ns period
   always #5 hclk = ~hclk;

   cm0_alu_pipe #(
      .PPB_NIBBLE (PPB_NIBBLE_DEF)
   ) dut_i (
      .hclk_i       (hclk),
      .rst_n_i      (rst_n),
      .in_valid_i   (in_valid),
      .op_i         (op),
      .opb_src_i    (opb_src),
      .imm_i        (imm),
      .ra_i         (ra),
      .rb_i         (rb),
      .cflag_i      (cflag_in),
      .agu_en_i     (agu_en),
      .agu_sel_ra_i (agu_sel_ra),
      .ls_size_i    (ls_size),
      .bus_idle_i   (bus_idle),
      .kill_addr_i  (kill_addr),
      .out_valid_o  (out_valid),
      .res_o        (res),
      .cflag_o      (cflag_out),
      .vflag_o      (vflag_out),
      .haddr_o      (haddr),
      .hsize_o      (hsize),
      .ext_trans_o  (ext_trans),
      .ppb_trans_o  (ppb_trans),
      .align_err_o  (align_err)
   );

   // ------------------------------------------------------------
   // checking and reference model
   // ------------------------------------------------------------

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // second operand before any inversion
   function automatic logic [31:0] opb_model(input opb_src_e src, input logic [11:0] im,
                                             input logic [31:0] b);
      case (src)
         IMM3:    return {29'd0, im[2:0]};
         IMM4X4:  return {26'd0, im[3:0], 2'b00};
         IMM8:    return {24'd0, im[7:0]};
         IMM8X4:  return {22'd0, im[7:0], 2'b00};
         IMM12S:  return {{20{im[11]}}, im};
         default: return b;
      endcase
   endfunction

   // returns overflow, carry and result packed as {v, c, res}
   function automatic logic [33:0] alu_model(input alu_op_e op_v, input logic [31:0] a,
                                             input logic [31:0] b, input logic cf);
      logic [31:0] xa;
      logic [31:0] xb;
      logic        ci;
      logic [32:0] sum;
      logic        v;
      logic [31:0] r;
      xa = a;
      xb = b;
      ci = 1'b0;
      case (op_v)
         ADC: ci = cf;
         SUB: begin
            xb = ~b;
            ci = 1'b1;
         end
         SBC: begin
            xb = ~b;
            ci = cf;
         end
         // zero minus b
         RSB: begin
            xa = 32'd0;
            xb = ~b;
            ci = 1'b1;
         end
         default: ;
      endcase
      sum = {1'b0, xa} + {1'b0, xb} + {32'd0, ci};
      // same operand signs, other sign in the sum
      v   = (xa[31] == xb[31]) && (sum[31] != xa[31]);
      case (op_v)
         AND:     r = a & b;
         BIC:     r = a & ~b;
         EOR:     r = a ^ b;
         ORR:     r = a | b;
         MOV:     r = b;
         MVN:     r = ~b;
         default: r = sum[31:0];
      endcase
      return {v, sum[32], r};
   endfunction

   `include "cm0_alu_pipe_tests.svh"

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------

   initial begin : main
      seed       = 31847;
      errors     = 0;
      checks     = 0;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      op         = ADD;
      opb_src    = REG;
      imm        = 12'h000;
      ra         = '0;
      rb         = '0;
      cflag_in   = 1'b0;
      agu_en     = 1'b0;
      agu_sel_ra = 1'b0;
      ls_size    = SIZE_BYTE;
      bus_idle   = 1'b0;
      kill_addr  = 1'b0;
      repeat (2) @(posedge hclk);
      @(negedge hclk);
      rst_n = 1'b1;

      test_reset();
      test_logic();
      test_arith();
      test_address();
      test_routing();
      test_burst();

      // assertion failures count as errors too
      errors = errors + dut_i.props_i.assert_fails;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin : watchdog
      #((TEST_CYCLES + MARGIN) * 10);
      $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/agu_bus_stage.sv
`default_nettype none

module agu_bus_stage #(
   parameter logic [3:0] PPB_NIBBLE = bus_pkg::PPB_NIBBLE_DEF
) (
   input  wire                          hclk_i,
   input  wire                          rst_n_i,
   input  wire                          ls_en_i,
   input  wire                          sel_ra_i,
   input  wire bus_pkg::hsize_e         size_i,
   input  wire                          suppress_i,
   input  wire [alu_pkg::DATA_W-1:0]    ra_i,
   input  wire [alu_pkg::DATA_W-1:0]    sum_i,
   output logic [bus_pkg::ADDR_W-1:0]   haddr_o,
   output bus_pkg::hsize_e              hsize_o,
   output logic                         ext_trans_o,
   output logic                         ppb_trans_o,
   output logic                         align_err_o
);

   import bus_pkg::*;

   logic [ADDR_W-1:0] addr_raw;   // address before alignment
   hsize_e            eff_size;   // byte when no load or store
   logic [1:0]        addr_mask;  // low bits cleared for the size
   logic              addr_ua;    // unaligned access
   logic              dvalid_tx;  // data transaction goes out
   logic              addr_ppb;   // address hits peripheral region

   // ------------------------------------------------------------
   // raw address and size
   // ------------------------------------------------------------

   // base register for plain loads, adder for offset forms
   assign addr_raw = sel_ra_i ? ra_i : sum_i;

   always_comb begin : size_sel
      eff_size = ls_en_i ? size_i : SIZE_BYTE;
   end

   // byte keeps both low bits, half clears bit 0, word bits 1:0
   always_comb begin : mask_gen
      case (eff_size)
         SIZE_BYTE: addr_mask = 2'b00;
         SIZE_HALF: addr_mask = 2'b01;
         default:   addr_mask = 2'b11;
      endcase
   end

   // ------------------------------------------------------------
   // alignment check and routing
   // ------------------------------------------------------------

   assign addr_ua   = ls_en_i & (|(addr_raw[1:0] & addr_mask));

   // misaligned or cancelled requests never reach a bus
   assign dvalid_tx = ls_en_i & ~suppress_i & ~addr_ua;

   assign addr_ppb  = addr_raw[ADDR_W-1:ADDR_W-4] == PPB_NIBBLE;

   // ------------------------------------------------------------
   // stage registers
   // ------------------------------------------------------------

   always_ff @(posedge hclk_i) begin : strobe_regs
      if (!rst_n_i) begin
         ext_trans_o <= 1'b0;
         ppb_trans_o <= 1'b0;
         align_err_o <= 1'b0;
      end else begin
         ext_trans_o <= dvalid_tx & ~addr_ppb;
         ppb_trans_o <= dvalid_tx & addr_ppb;
         align_err_o <= addr_ua;
      end
   end

   // address is always presented aligned to the size
   always_ff @(posedge hclk_i) begin : addr_regs
      haddr_o <= {addr_raw[ADDR_W-1:2], addr_raw[1:0] & ~addr_mask};
      hsize_o <= eff_size;
   end

endmodule

`default_nettype wire

// File: hdl/alu_execute_stage.sv
`default_nettype none

module alu_execute_stage (
   input  wire                          hclk_i,
   input  wire                          rst_n_i,
   input  wire                          valid_i,
   input  wire alu_pkg::alu_op_e        op_i,
   input  wire [alu_pkg::DATA_W-1:0]    opa_i,
   input  wire [alu_pkg::DATA_W-1:0]    opb_i,
   input  wire                          cin_i,
   input  wire [alu_pkg::DATA_W-1:0]    ra_i,
   output logic [alu_pkg::DATA_W-1:0]   sum_o,
   output logic                         valid_o,
   output logic [alu_pkg::DATA_W-1:0]   res_o,
   output logic                         cflag_o,
   output logic                         vflag_o
);

   import alu_pkg::*;

   logic [DATA_W:0]   add_res;   // sum with carry-out on top
   logic              ops_same;  // adder operands share a sign
   logic              res_diff;  // sum sign differs from operand a
   logic              overflow;
   logic [DATA_W-1:0] res;

   // ------------------------------------------------------------
   // adder
   // ------------------------------------------------------------

   // single 33 bit adder shared by arithmetic and the address path
   assign add_res = {1'b0, opa_i} + {1'b0, opb_i} + {{DATA_W{1'b0}}, cin_i};

   // raw sum goes straight to the address stage
   assign sum_o = add_res[DATA_W-1:0];

   // signed overflow
   // operands of equal sign but a sum of the other sign
   assign ops_same = ~(opa_i[DATA_W-1] ^ opb_i[DATA_W-1]);
   assign res_diff = opa_i[DATA_W-1] ^ add_res[DATA_W-1];
   assign overflow = ops_same & res_diff;

   // ------------------------------------------------------------
   // logic ops and result mux
   // ------------------------------------------------------------

   // logic ops use raw a, b already inverted for BIC and MVN
   always_comb begin : res_mux
      case (op_i)
         ADD, ADC, SUB, SBC, RSB: res = add_res[DATA_W-1:0];
         AND, BIC:                res = ra_i & opb_i;
         EOR:                     res = ra_i ^ opb_i;
         ORR:                     res = ra_i | opb_i;
         // move ops pass operand b through
         MOV, MVN:                res = opb_i;
         default:                 res = '0;
      endcase
   end

   // ------------------------------------------------------------
   // stage registers
   // ------------------------------------------------------------

   always_ff @(posedge hclk_i) begin : valid_reg
      if (!rst_n_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   // flags only mean something for the arithmetic ops
   always_ff @(posedge hclk_i) begin : res_regs
      res_o   <= res;
      cflag_o <= add_res[DATA_W];
      vflag_o <= overflow;
   end

endmodule

`default_nettype wire

// File: hdl/alu_operand_stage.sv
`default_nettype none

module alu_operand_stage (
   input  wire                          hclk_i,
   input  wire                          rst_n_i,
   input  wire                          in_valid_i,
   input  wire alu_pkg::alu_op_e        op_i,
   input  wire alu_pkg::opb_src_e       opb_src_i,
   input  wire [11:0]                   imm_i,
   input  wire [alu_pkg::DATA_W-1:0]    ra_i,
   input  wire [alu_pkg::DATA_W-1:0]    rb_i,
   input  wire                          cflag_i,
   input  wire                          agu_en_i,
   input  wire                          agu_sel_ra_i,
   input  wire bus_pkg::hsize_e         ls_size_i,
   input  wire                          bus_idle_i,
   input  wire                          kill_addr_i,
   output logic                         valid_o,
   output alu_pkg::alu_op_e             op_o,
   output logic [alu_pkg::DATA_W-1:0]   opa_o,
   output logic [alu_pkg::DATA_W-1:0]   opb_o,
   output logic                         cin_o,
   output logic [alu_pkg::DATA_W-1:0]   ra_o,
   output logic                         ls_en_o,
   output logic                         sel_ra_o,
   output bus_pkg::hsize_e              size_o,
   output logic                         suppress_o
);

   import alu_pkg::*;

   logic [DATA_W-1:0] opb_sel;   // operand b before inversion
   logic              inv_b;     // invert operand b
   logic              zero_a;    // force operand a to zero
   logic              cin;       // adder carry-in

   // ------------------------------------------------------------
   // operand b select
   // ------------------------------------------------------------

   // any scaling of the immediate is done here, not in decode
   always_comb begin : opb_mux
      case (opb_src_i)
         REG:     opb_sel = rb_i;
         IMM3:    opb_sel = {{(DATA_W-3){1'b0}}, imm_i[2:0]};
         IMM4X4:  opb_sel = {{(DATA_W-6){1'b0}}, imm_i[3:0], 2'b00};
         IMM8:    opb_sel = {{(DATA_W-8){1'b0}}, imm_i[7:0]};
         IMM8X4:  opb_sel = {{(DATA_W-10){1'b0}}, imm_i[7:0], 2'b00};
         IMM12S:  opb_sel = {{(DATA_W-12){imm_i[11]}}, imm_i};
         // unused encodings read as zero
         default: opb_sel = '0;
      endcase
   end

   // ------------------------------------------------------------
   // operand conditioning and carry-in
   // ------------------------------------------------------------

   // subtracts are a + ~b + 1, borrow forms take the carry flag
   always_comb begin : op_cond
      inv_b  = 1'b0;
      zero_a = 1'b0;
      cin    = 1'b0;
      case (op_i)
         ADC: cin = cflag_i;
         SUB: begin
            inv_b = 1'b1;
            cin   = 1'b1;
         end
         SBC: begin
            inv_b = 1'b1;
            cin   = cflag_i;
         end
         // negate: 0 + ~b + 1
         RSB: begin
            inv_b  = 1'b1;
            zero_a = 1'b1;
            cin    = 1'b1;
         end
         // logic unit sees the inverted b directly
         BIC, MVN: inv_b = 1'b1;
         default: ;
      endcase
   end

   // ------------------------------------------------------------
   // stage registers
   // ------------------------------------------------------------

   always_ff @(posedge hclk_i) begin : ctl_regs
      if (!rst_n_i) begin
         valid_o <= 1'b0;
         ls_en_o <= 1'b0;
      end else begin
         valid_o <= in_valid_i;
         // only place the load/store request is qualified
         ls_en_o <= in_valid_i & agu_en_i;
      end
   end

   always_ff @(posedge hclk_i) begin : data_regs
      op_o       <= op_i;
      opa_o      <= zero_a ? '0 : ra_i;
      opb_o      <= opb_sel ^ {DATA_W{inv_b}};
      cin_o      <= cin;
      ra_o       <= ra_i;
      sel_ra_o   <= agu_sel_ra_i;
      size_o     <= ls_size_i;
      // either source cancels the bus transaction
      suppress_o <= bus_idle_i | kill_addr_i;
   end

endmodule

`default_nettype wire

// File: hdl/alu_pkg.sv
`default_nettype none

package alu_pkg;

   // ------------------------------------------------------------
   // data path
   // ------------------------------------------------------------

   // width of the register read ports and of the result
   localparam int DATA_W = 32;

   // ------------------------------------------------------------
   // operation and operand source encodings
   // ------------------------------------------------------------

   // arithmetic ops go through the adder, the rest use the logic unit
   typedef enum logic [3:0] {
      ADD = 4'd0,
      ADC = 4'd1,
      SUB = 4'd2,
      SBC = 4'd3,
      RSB = 4'd4,    // zero minus b
      AND = 4'd5,
      BIC = 4'd6,    // a and not b
      EOR = 4'd7,
      ORR = 4'd8,
      MOV = 4'd9,
      MVN = 4'd10
   } alu_op_e;

   // where the second operand comes from
   typedef enum logic [2:0] {
      REG    = 3'd0,   // read-port b
      IMM3   = 3'd1,   // imm[2:0], zero extended
      IMM4X4 = 3'd2,   // imm[3:0] times four
      IMM8   = 3'd3,   // imm[7:0], zero extended
      IMM8X4 = 3'd4,   // imm[7:0] times four
      IMM12S = 3'd5    // imm[11:0], sign extended
   } opb_src_e;

endpackage

`default_nettype wire

// File: hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

   // ------------------------------------------------------------
   // data-side bus definitions
   // ------------------------------------------------------------

   // width of the bus address
   localparam int ADDR_W = 32;

   // transfer size, same encoding as the bus size field
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } hsize_e;

   // top address nibble that selects the private peripheral bus
   localparam logic [3:0] PPB_NIBBLE_DEF = 4'hE;

endpackage

`default_nettype wire

// File: hdl/cm0_alu_pipe.sv
`default_nettype none

module cm0_alu_pipe #(
   parameter logic [3:0] PPB_NIBBLE = bus_pkg::PPB_NIBBLE_DEF
) (
   input  wire                          hclk_i,
   input  wire                          rst_n_i,
   input  wire                          in_valid_i,
   input  wire alu_pkg::alu_op_e        op_i,
   input  wire alu_pkg::opb_src_e       opb_src_i,
   input  wire [11:0]                   imm_i,
   input  wire [alu_pkg::DATA_W-1:0]    ra_i,
   input  wire [alu_pkg::DATA_W-1:0]    rb_i,
   input  wire                          cflag_i,
   input  wire                          agu_en_i,
   input  wire                          agu_sel_ra_i,
   input  wire bus_pkg::hsize_e         ls_size_i,
   input  wire                          bus_idle_i,
   input  wire                          kill_addr_i,
   output logic                         out_valid_o,
   output logic [alu_pkg::DATA_W-1:0]   res_o,
   output logic                         cflag_o,
   output logic                         vflag_o,
   output logic [bus_pkg::ADDR_W-1:0]   haddr_o,
   output bus_pkg::hsize_e              hsize_o,
   output logic                         ext_trans_o,
   output logic                         ppb_trans_o,
   output logic                         align_err_o
);

   import alu_pkg::*;
   import bus_pkg::*;

   // ------------------------------------------------------------
   // operand stage to execute and address stages
   // ------------------------------------------------------------

   logic              s1_valid;
   alu_op_e           s1_op;
   logic [DATA_W-1:0] s1_opa;
   logic [DATA_W-1:0] s1_opb;
   logic              s1_cin;
   logic [DATA_W-1:0] s1_ra;
   logic              s1_ls_en;
   logic              s1_sel_ra;
   hsize_e            s1_size;
   logic              s1_suppress;

   // combinational adder output feeding the address stage
   logic [DATA_W-1:0] ex_sum;

   alu_operand_stage u_operand (
      .hclk_i       (hclk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i),
      .op_i         (op_i),
      .opb_src_i    (opb_src_i),
      .imm_i        (imm_i),
      .ra_i         (ra_i),
      .rb_i         (rb_i),
      .cflag_i      (cflag_i),
      .agu_en_i     (agu_en_i),
      .agu_sel_ra_i (agu_sel_ra_i),
      .ls_size_i    (ls_size_i),
      .bus_idle_i   (bus_idle_i),
      .kill_addr_i  (kill_addr_i),
      .valid_o      (s1_valid),
      .op_o         (s1_op),
      .opa_o        (s1_opa),
      .opb_o        (s1_opb),
      .cin_o        (s1_cin),
      .ra_o         (s1_ra),
      .ls_en_o      (s1_ls_en),
      .sel_ra_o     (s1_sel_ra),
      .size_o       (s1_size),
      .suppress_o   (s1_suppress)
   );

   // ------------------------------------------------------------
   // second stage, execute and address side by side
   // ------------------------------------------------------------

   alu_execute_stage u_execute (
      .hclk_i  (hclk_i),
      .rst_n_i (rst_n_i),
      .valid_i (s1_valid),
      .op_i    (s1_op),
      .opa_i   (s1_opa),
      .opb_i   (s1_opb),
      .cin_i   (s1_cin),
      .ra_i    (s1_ra),
      .sum_o   (ex_sum),
      .valid_o (out_valid_o),
      .res_o   (res_o),
      .cflag_o (cflag_o),
      .vflag_o (vflag_o)
   );

   agu_bus_stage #(
      .PPB_NIBBLE (PPB_NIBBLE)
   ) u_agu (
      .hclk_i      (hclk_i),
      .rst_n_i     (rst_n_i),
      .ls_en_i     (s1_ls_en),
      .sel_ra_i    (s1_sel_ra),
      .size_i      (s1_size),
      .suppress_i  (s1_suppress),
      .ra_i        (s1_ra),
      .sum_i       (ex_sum),
      .haddr_o     (haddr_o),
      .hsize_o     (hsize_o),
      .ext_trans_o (ext_trans_o),
      .ppb_trans_o (ppb_trans_o),
      .align_err_o (align_err_o)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the exit status is nonzero unless the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module cm0_alu_pipe_tb \
   -f cm0_alu_pipe.f \
   -o cm0_alu_pipe_sim \
   && ./obj_dir/cm0_alu_pipe_sim | tee /dev/stderr | grep "All tests passed" > /dev/null \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation failed"; exit 1; }
